//--- verif/mem_glue_testdata.txt
# op addr kind wdata unc kill | route size byteen lane_data rdata
# op F fetch, L load, S store, P load and uncached fetch together; route I D U X M
F 00001000 2 00000000 0 0 U 2 f 00000000 24000001
F 00001004 2 00000000 0 0 U 2 f 00000000 24000002
F 00001008 2 00000000 0 0 U 2 f 00000000 24000003
F 0000100c 2 00000000 0 0 I 2 f 00000000 00000000
F 00002000 2 00000000 1 0 U 2 f 00000000 3c1d0010
S 00000100 0 000000a5 0 0 D 0 1 a5a5a5a5 00000000
S 00000103 0 000000a5 0 0 D 0 8 a5a5a5a5 00000000
S 00000102 1 0000beef 0 0 D 1 c beefbeef 00000000
S 00000100 2 12345678 0 0 D 2 f 12345678 00000000
L 00000101 0 00000000 0 0 D 0 2 00000000 00000000
L 00000100 1 00000000 0 0 D 1 3 00000000 00000000
L 00000204 2 00000000 1 0 U 2 f 00000000 cafef00d
S 00000206 1 00001234 1 0 U 1 c 12341234 00000000
S 00000201 0 0000007e 1 0 U 0 2 7e7e7e7e 00000000
L 00000202 1 00000000 1 0 U 1 c 00000000 0000abcd
L 00000301 1 00000000 0 0 M 1 0 00000000 00000000
S 00000302 2 11223344 0 0 M 2 0 00000000 00000000
L 00000303 2 00000000 1 0 M 2 0 00000000 00000000
S 00000100 2 55667788 0 1 X 2 0 00000000 00000000
L 00000101 2 00000000 1 1 X 2 0 00000000 00000000
P 00000400 2 00000000 1 0 U 2 f 00000000 87654321
F 00001010 2 00000000 0 0 I 2 f 00000000 00000000

//--- sources.f
common/mem_glue_pkg.sv
hw/inst_route.sv
data_route/data_route.sv
unc_arbiter/unc_arbiter.sv
hw/mem_glue_top.sv
verif/mem_glue_props.sv
verif/tb_mem_glue.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_glue
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- verif/tb_mem_glue.sv
`timescale 1ns/1ps

module tb_mem_glue;

    logic                      Clk;
    logic                      Myreset;
    mem_glue_pkg::fetch_req_t  i_fetch;
    mem_glue_pkg::mem_op_t     i_mem_op;
    mem_glue_pkg::unc_rsp_t    i_unc_rsp;
    mem_glue_pkg::icache_req_t o_icache_req;
    mem_glue_pkg::dcache_req_t o_dcache_req;
    logic                      o_misaligned;
    mem_glue_pkg::unc_req_t    o_unc_req;
    mem_glue_pkg::unc_rsp_t    o_inst_rsp;
    mem_glue_pkg::unc_rsp_t    o_data_rsp;
    int                        n_ops = 0;

    mem_glue_top mem_glue_top_inst (.*);

    always #20 Clk = ~Clk;

    // ##############################
    // Failure and compare tasks
    // ##############################
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_icache(input mem_glue_pkg::icache_req_t got, exp);
        if (got !== exp) stop_run($sformatf("ERR %0t: icache req got %h exp %h", $time, got, exp));
    endtask

    task automatic check_dcache(input mem_glue_pkg::dcache_req_t got, exp);
        if (got !== exp) stop_run($sformatf("ERR %0t: dcache req got %h exp %h", $time, got, exp));
    endtask

    task automatic check_unc_req(input mem_glue_pkg::unc_req_t got, exp);
        if (got !== exp) stop_run($sformatf("ERR %0t: unc req got %h exp %h", $time, got, exp));
    endtask

    task automatic check_unc_rsp(input mem_glue_pkg::unc_rsp_t got, exp);
        if (got !== exp) stop_run($sformatf("ERR %0t: unc rsp got %h exp %h", $time, got, exp));
    endtask

    // ##############################
    // Uncached responder
    // ##############################
    task automatic serve_unc(input mem_glue_pkg::unc_req_t exp, input logic [31:0] rdata,
                             input bit data_side);
        int                     wait_cnt;
        int                     delay;
        mem_glue_pkg::unc_rsp_t exp_rsp;
        wait_cnt = 0;
        while (!o_unc_req.valid) begin
            @(negedge Clk);
            wait_cnt++;
            if (wait_cnt > 20) stop_run("No uncached request appeared on the external bus");
        end
        check_unc_req(o_unc_req, exp);
        delay = $urandom_range(6, 1);
        repeat (delay) @(negedge Clk);
        i_unc_rsp.ok    = 1'b1;
        i_unc_rsp.rdata = rdata;
        @(negedge Clk);
        i_unc_rsp.ok = 1'b0;
        exp_rsp.ok    = 1'b1;
        exp_rsp.rdata = rdata;
        check_unc_rsp(data_side ? o_data_rsp : o_inst_rsp, exp_rsp);   // Owner answers one cycle on
        if ((data_side ? o_inst_rsp.ok : o_data_rsp.ok) !== 1'b0)
            stop_run("Response returned on the wrong side");
    endtask

    // ##############################
    // Stimulus from file
    // ##############################
    initial begin
        int                        fd;
        int                        code;
        string                     line;
        byte                       op;
        byte                       rt;
        logic [31:0]               addr;
        logic [31:0]               wdata;
        logic [31:0]               be_v;
        logic [31:0]               lane;
        logic [31:0]               rdata;
        int                        kind_v;
        int                        unc;
        int                        kill;
        int                        size_v;
        mem_glue_pkg::unc_req_t    exp_unc;
        mem_glue_pkg::unc_req_t    exp_fetch;
        mem_glue_pkg::icache_req_t exp_ic;
        mem_glue_pkg::dcache_req_t exp_dc;

        void'($urandom(32'h2c6e_1357));
        Clk       = 1'b0;
        Myreset   = 1'b1;
        i_fetch   = '0;
        i_mem_op  = '0;
        i_unc_rsp = '0;

        fd = $fopen("verif/mem_glue_testdata.txt", "r");
        if (fd == 0) stop_run("Could not open the test data file");
        while ($fgets(line, fd)) begin
            if (line.len() > 10 && line[0] != "#") n_ops++;
        end
        $fclose(fd);
        fd = $fopen("verif/mem_glue_testdata.txt", "r");

        repeat (16) @(negedge Clk);
        Myreset = 1'b0;
        @(negedge Clk);

        while ($fgets(line, fd)) begin
            if (line.len() <= 10 || line[0] == "#") continue;
            code = $sscanf(line, "%c %h %d %h %d %d %c %d %h %h %h", op, addr, kind_v, wdata,
                           unc, kill, rt, size_v, be_v, lane, rdata);
            if (code != 11) stop_run($sformatf("Bad test data line: %s", line));
            if (op == "F" || op == "P") begin
                i_fetch.valid    = 1'b1;
                i_fetch.pc       = addr;
                i_fetch.uncached = unc[0];
            end
            if (op != "F") begin
                i_mem_op.read     = (op != "S");
                i_mem_op.write    = (op == "S");
                i_mem_op.kind     = mem_glue_pkg::acc_kind_t'(kind_v);
                i_mem_op.addr     = addr;
                i_mem_op.wdata    = wdata;
                i_mem_op.uncached = unc[0];
                i_mem_op.kill     = kill[0];
            end
            @(negedge Clk);
            i_fetch  = '0;
            i_mem_op = '0;

            // Routing stage result, one cycle after the strobe
            if (o_misaligned !== (rt == "M")) stop_run("Misaligned flag does not match the op");
            if (rt != "I" && o_icache_req.valid !== 1'b0) stop_run("Unexpected icache request");
            if (rt != "D" && o_dcache_req.valid !== 1'b0) stop_run("Unexpected dcache request");
            exp_ic.valid = 1'b1;
            exp_ic.addr  = addr;
            exp_dc.valid  = 1'b1;
            exp_dc.write  = (op == "S");
            exp_dc.addr   = addr;
            exp_dc.byteen = be_v[3:0];
            exp_dc.wdata  = lane;
            exp_unc.valid  = 1'b1;
            exp_unc.write  = (op == "S");
            exp_unc.addr   = addr;
            exp_unc.size   = mem_glue_pkg::acc_size_t'(size_v);
            exp_unc.byteen = be_v[3:0];
            exp_unc.wdata  = lane;
            if (rt == "I") check_icache(o_icache_req, exp_ic);
            if (rt == "D") check_dcache(o_dcache_req, exp_dc);
            if (rt == "U") begin
                serve_unc(exp_unc, rdata, op != "F");
                if (op == "P") begin
                    exp_fetch        = exp_unc;                   // Fetch side waited behind data
                    exp_fetch.write  = 1'b0;
                    exp_fetch.size   = mem_glue_pkg::SIZE_4;
                    exp_fetch.byteen = 4'hf;
                    exp_fetch.wdata  = '0;
                    serve_unc(exp_fetch, ~rdata, 1'b0);
                end
            end
            if (rt == "X" || rt == "M") begin
                @(negedge Clk);                                   // Arbiter issue slot
                if (o_unc_req.valid !== 1'b0) stop_run("Blocked op reached the uncached bus");
            end
            @(negedge Clk);
        end
        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

    // ##############################
    // Watchdog
    // ##############################
    initial begin
        wait (n_ops > 0);
        #(n_ops * 30 * 40 + 16 * 40);                         // 30 cycles of 40 ns per op
        $display("Timeout: the run did not finish in time");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

endmodule

//--- verif/mem_glue_props.sv
`timescale 1ns/1ps

module mem_glue_props (
    input logic                   Clk,
    input logic                   Myreset,
    input mem_glue_pkg::unc_req_t o_unc_req,
    input mem_glue_pkg::unc_rsp_t i_unc_rsp,
    input mem_glue_pkg::unc_rsp_t o_inst_rsp,
    input mem_glue_pkg::unc_rsp_t o_data_rsp
);

    logic outstanding;                                        // Request out, ok not yet seen

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            outstanding <= 1'b0;
        end else if (o_unc_req.valid) begin
            outstanding <= 1'b1;
        end else if (i_unc_rsp.ok) begin
            outstanding <= 1'b0;
        end
    end

    a_req_pulse: assert property (@(posedge Clk) disable iff (Myreset)
        o_unc_req.valid |=> !o_unc_req.valid)
        else $error("uncached request valid held for more than one cycle");

    a_single_outstanding: assert property (@(posedge Clk) disable iff (Myreset)
        outstanding |-> !o_unc_req.valid)
        else $error("new uncached request issued before the ok pulse");

    // One side only, and only after a bus ok for an outstanding request
    a_rsp_exclusive: assert property (@(posedge Clk) disable iff (Myreset)
        (o_inst_rsp.ok || o_data_rsp.ok) |->
            !(o_inst_rsp.ok && o_data_rsp.ok) && $past(i_unc_rsp.ok && outstanding))
        else $error("response ok on both sides or without a matching bus ok");

endmodule

bind unc_arbiter mem_glue_props mem_glue_props_inst (
    .Clk        (Clk),
    .Myreset    (Myreset),
    .o_unc_req  (o_unc_req),
    .i_unc_rsp  (i_unc_rsp),
    .o_inst_rsp (o_inst_rsp),
    .o_data_rsp (o_data_rsp)
);

//--- hw/mem_glue_top.sv
`timescale 1ns/1ps

module mem_glue_top (
    input  logic                      Clk,
    input  logic                      Myreset,
    input  mem_glue_pkg::fetch_req_t  i_fetch,
    input  mem_glue_pkg::mem_op_t     i_mem_op,
    input  mem_glue_pkg::unc_rsp_t    i_unc_rsp,
    output mem_glue_pkg::icache_req_t o_icache_req,
    output mem_glue_pkg::dcache_req_t o_dcache_req,
    output logic                      o_misaligned,
    output mem_glue_pkg::unc_req_t    o_unc_req,
    output mem_glue_pkg::unc_rsp_t    o_inst_rsp,
    output mem_glue_pkg::unc_rsp_t    o_data_rsp
);

    mem_glue_pkg::unc_req_t inst_unc;
    mem_glue_pkg::unc_req_t data_unc;
    logic                   caches_closed;

    inst_route inst_route_inst (
        .Clk             (Clk),
        .Myreset         (Myreset),
        .i_fetch         (i_fetch),
        .i_inst_rsp      (o_inst_rsp),                    // Completions drive the warm-up count
        .o_icache_req    (o_icache_req),
        .o_inst_unc      (inst_unc),
        .o_caches_closed (caches_closed)
    );

    data_route data_route_inst (
        .Clk             (Clk),
        .Myreset         (Myreset),
        .i_mem_op        (i_mem_op),
        .i_caches_closed (caches_closed),
        .o_dcache_req    (o_dcache_req),
        .o_data_unc      (data_unc),
        .o_misaligned    (o_misaligned)
    );

    unc_arbiter unc_arbiter_inst (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .i_inst_unc (inst_unc),
        .i_data_unc (data_unc),
        .i_unc_rsp  (i_unc_rsp),
        .o_unc_req  (o_unc_req),
        .o_inst_rsp (o_inst_rsp),
        .o_data_rsp (o_data_rsp)
    );

endmodule

//--- unc_arbiter/unc_arbiter.sv
`timescale 1ns/1ps

module unc_arbiter (
    input  logic                   Clk,
    input  logic                   Myreset,
    input  mem_glue_pkg::unc_req_t i_inst_unc,
    input  mem_glue_pkg::unc_req_t i_data_unc,
    input  mem_glue_pkg::unc_rsp_t i_unc_rsp,
    output mem_glue_pkg::unc_req_t o_unc_req,
    output mem_glue_pkg::unc_rsp_t o_inst_rsp,
    output mem_glue_pkg::unc_rsp_t o_data_rsp
);

    mem_glue_pkg::unc_req_t inst_q;
    mem_glue_pkg::unc_req_t data_q;
    mem_glue_pkg::unc_req_t inst_cur;
    mem_glue_pkg::unc_req_t data_cur;
    logic                   inst_pend;
    logic                   data_pend;
    logic                   inst_avail;
    logic                   data_avail;
    logic                   issue_inst;
    logic                   issue_data;
    logic                   busy;
    logic                   owner_data;

    // ##############################
    // Pending requests
    // ##############################
    assign inst_cur   = inst_pend ? inst_q : i_inst_unc;  // A fresh request bypasses its slot
    assign data_cur   = data_pend ? data_q : i_data_unc;
    assign inst_avail = inst_pend | i_inst_unc.valid;
    assign data_avail = data_pend | i_data_unc.valid;

    // Data side wins when both wait
    assign issue_data = ~busy & data_avail;
    assign issue_inst = ~busy & ~data_avail & inst_avail;

    always_ff @(posedge Clk) begin
        if (i_inst_unc.valid) begin
            inst_q <= i_inst_unc;
        end
        if (i_data_unc.valid) begin
            data_q <= i_data_unc;
        end
    end

    // ##############################
    // Single outstanding access
    // ##############################
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            inst_pend       <= 1'b0;
            data_pend       <= 1'b0;
            busy            <= 1'b0;
            owner_data      <= 1'b0;
            o_unc_req.valid <= 1'b0;
            o_inst_rsp.ok   <= 1'b0;
            o_data_rsp.ok   <= 1'b0;
        end else begin
            inst_pend       <= inst_avail & ~issue_inst;
            data_pend       <= data_avail & ~issue_data;
            o_unc_req.valid <= issue_data | issue_inst;
            if (issue_data || issue_inst) begin
                busy       <= 1'b1;
                owner_data <= issue_data;
            end else if (i_unc_rsp.ok) begin
                busy <= 1'b0;
            end
            o_inst_rsp.ok <= i_unc_rsp.ok & busy & ~owner_data;
            o_data_rsp.ok <= i_unc_rsp.ok & busy & owner_data;
        end
    end

    always_ff @(posedge Clk) begin
        if (issue_data) begin
            o_unc_req.write  <= data_cur.write;
            o_unc_req.addr   <= data_cur.addr;
            o_unc_req.size   <= data_cur.size;
            o_unc_req.byteen <= data_cur.byteen;
            o_unc_req.wdata  <= data_cur.wdata;
        end else if (issue_inst) begin
            o_unc_req.write  <= inst_cur.write;
            o_unc_req.addr   <= inst_cur.addr;
            o_unc_req.size   <= inst_cur.size;
            o_unc_req.byteen <= inst_cur.byteen;
            o_unc_req.wdata  <= inst_cur.wdata;
        end
        o_inst_rsp.rdata <= i_unc_rsp.rdata;
        o_data_rsp.rdata <= i_unc_rsp.rdata;              // Only the owner's ok qualifies it
    end

endmodule

//--- data_route/data_route.sv
`timescale 1ns/1ps

module data_route (
    input  logic                      Clk,
    input  logic                      Myreset,
    input  mem_glue_pkg::mem_op_t     i_mem_op,
    input  logic                      i_caches_closed,
    output mem_glue_pkg::dcache_req_t o_dcache_req,
    output mem_glue_pkg::unc_req_t    o_data_unc,
    output logic                      o_misaligned
);

    mem_glue_pkg::acc_size_t              size;
    logic [mem_glue_pkg::BE_W-1:0]        byteen;
    logic [mem_glue_pkg::DATA_W-1:0]      lane_wdata;
    logic                                 bad_align;
    logic                                 access;
    logic                                 accept;
    logic                                 go_unc;

    // ##############################
    // Size and lane decode
    // ##############################
    always_comb begin
        case (i_mem_op.kind)
            mem_glue_pkg::KIND_BYTE: begin
                size       = mem_glue_pkg::SIZE_1;
                byteen     = 4'b0001 << i_mem_op.addr[1:0];
                lane_wdata = {4{i_mem_op.wdata[7:0]}};
                bad_align  = 1'b0;
            end
            mem_glue_pkg::KIND_HALF: begin
                size       = mem_glue_pkg::SIZE_2;
                byteen     = i_mem_op.addr[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{i_mem_op.wdata[15:0]}};
                bad_align  = i_mem_op.addr[0];                // Odd halfword address
            end
            default: begin                                    // Word, unused code decodes as word
                size       = mem_glue_pkg::SIZE_4;
                byteen     = 4'b1111;
                lane_wdata = i_mem_op.wdata;
                bad_align  = |i_mem_op.addr[1:0];
            end
        endcase
    end

    // ##############################
    // Blocking and steering
    // ##############################
    assign access = (i_mem_op.read | i_mem_op.write) & ~i_mem_op.kill;
    assign accept = access & ~bad_align;
    assign go_unc = i_mem_op.uncached | i_caches_closed;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            o_dcache_req.valid <= 1'b0;
            o_data_unc.valid   <= 1'b0;
            o_misaligned       <= 1'b0;
        end else begin
            o_dcache_req.valid <= accept & ~go_unc;
            o_data_unc.valid   <= accept & go_unc;
            o_misaligned       <= access & bad_align;         // Killed ops stay silent
        end
    end

    always_ff @(posedge Clk) begin
        o_dcache_req.write  <= i_mem_op.write;
        o_dcache_req.addr   <= i_mem_op.addr;
        o_dcache_req.byteen <= byteen;
        o_dcache_req.wdata  <= lane_wdata;
        o_data_unc.write    <= i_mem_op.write;
        o_data_unc.addr     <= i_mem_op.addr;
        o_data_unc.size     <= size;
        o_data_unc.byteen   <= byteen;
        o_data_unc.wdata    <= lane_wdata;
    end

endmodule

//--- hw/inst_route.sv
`timescale 1ns/1ps

module inst_route (
    input  logic                     Clk,
    input  logic                     Myreset,
    input  mem_glue_pkg::fetch_req_t i_fetch,
    input  mem_glue_pkg::unc_rsp_t   i_inst_rsp,
    output mem_glue_pkg::icache_req_t o_icache_req,
    output mem_glue_pkg::unc_req_t   o_inst_unc,
    output logic                     o_caches_closed
);

    logic [mem_glue_pkg::WARMUP_CNT_W-1:0] warm_cnt;
    logic                                  closed;
    logic                                  go_unc;

    // ##############################
    // Cache warm-up
    // ##############################
    assign closed          = warm_cnt != mem_glue_pkg::WARMUP_CNT_W'(mem_glue_pkg::WARMUP_FETCHES);
    assign o_caches_closed = closed;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            warm_cnt <= '0;
        end else if (i_inst_rsp.ok && closed) begin
            warm_cnt <= warm_cnt + 1'b1;                      // Saturates once the caches open
        end
    end

    // ##############################
    // Fetch steering
    // ##############################
    assign go_unc = i_fetch.uncached | closed;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            o_icache_req.valid <= 1'b0;
            o_inst_unc.valid   <= 1'b0;
        end else begin
            o_icache_req.valid <= i_fetch.valid & ~go_unc;
            o_inst_unc.valid   <= i_fetch.valid & go_unc;
        end
    end

    always_ff @(posedge Clk) begin
        o_icache_req.addr <= i_fetch.pc;
        o_inst_unc.write  <= 1'b0;                            // Fetches only read
        o_inst_unc.addr   <= i_fetch.pc;
        o_inst_unc.size   <= mem_glue_pkg::SIZE_4;
        o_inst_unc.byteen <= '1;
        o_inst_unc.wdata  <= '0;
    end

endmodule

//--- common/mem_glue_pkg.sv
package mem_glue_pkg;

    // ##############################
    // Widths and counts
    // ##############################
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BE_W           = 4;
    localparam int WARMUP_FETCHES = 3;                        // Uncached fetch completions before caches open
    localparam int WARMUP_CNT_W   = $clog2(WARMUP_FETCHES + 1);

    // ##############################
    // Access encodings
    // ##############################
    typedef enum logic [1:0] {
        KIND_BYTE = 2'd0,
        KIND_HALF = 2'd1,
        KIND_WORD = 2'd2
    } acc_kind_t;

    typedef enum logic [2:0] {
        SIZE_1 = 3'd0,
        SIZE_2 = 3'd1,
        SIZE_4 = 3'd2                                         // Same codes as the bus size field
    } acc_size_t;

    // ##############################
    // Request and response bundles
    // ##############################
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic              uncached;
    } fetch_req_t;

    typedef struct packed {
        logic              read;
        logic              write;
        acc_kind_t         kind;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;                             // Unaligned, low bytes hold the value
        logic              uncached;
        logic              kill;
    } mem_op_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } icache_req_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   byteen;
        logic [DATA_W-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        acc_size_t         size;
        logic [BE_W-1:0]   byteen;
        logic [DATA_W-1:0] wdata;
    } unc_req_t;

    typedef struct packed {
        logic              ok;
        logic [DATA_W-1:0] rdata;
    } unc_rsp_t;

endpackage
